// File: bench/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb import mipsPkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_ROWS = 12;
	localparam int STORE_LIMIT = 50;
	localparam int WATCHDOG_NS = NUM_ROWS * (RESET_CYCLES + 60) * CLK_PERIOD;
	localparam logic [31:0] STORE_ADDR = 32'h0000_0200;
	localparam logic [15:0] STORE_OFS = 16'h0200;
	localparam logic [15:0] LOAD_OFS = 16'h0300;
	localparam logic [15:0] FALL_MARK = 16'h1111;
	localparam logic [15:0] TAKEN_MARK = 16'h2222;

	// Paired rows run an R-type op, then an I-type op with opB as immediate
	typedef enum logic [3:0] {
		T_ADD_ANDI, T_SUB_ORI, T_AND_XORI, T_OR_ADDI, T_XOR_SLTI, T_SLT_XORI,
		T_LW, T_BEQ, T_BNE, T_JUMP
	} testOp_t;

	typedef struct packed {
		testOp_t op;
		logic [15:0] opA;
		logic [15:0] opB;
		logic [31:0] expAddr;
		logic [31:0] expData;
	} caseRow_t;

	logic cclk;
	logic rstb;
	logic [31:0] readData;
	logic [31:0] memAddr;
	logic [31:0] writeData;
	logic memWrite;

	logic [31:0] mem [256];
	caseRow_t caseTable [NUM_ROWS];
	logic [7:0] progPtr;
	integer seed;
	int errorCount;
	int passCount;
	int failCount;

	// Unified memory, combinational read
	assign readData = mem[memAddr[9:2]];

	mipsMulticycle i_mipsMulticycle (
		.cclk(cclk),
		.rstb(rstb),
		.readData(readData),
		.memAddr(memAddr),
		.writeData(writeData),
		.memWrite(memWrite)
	);

	initial begin
		cclk = 1'b0;
		forever #(CLK_PERIOD / 2) cclk = ~cclk;
	end

	function automatic logic [31:0] rTypeWord(input logic [5:0] funct, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd);
		return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] iTypeWord(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Target given as word address inside the first KB
	function automatic logic [31:0] jumpWord(input logic [7:0] wordAddr);
		return {OP_J, 18'd0, wordAddr};
	endfunction

	// Reference result of a paired row
	function automatic logic [31:0] expectedAlu(input testOp_t op, input logic [15:0] aImm,
			input logic [15:0] bImm);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] bz;
		logic [31:0] r;
		a = {{16{aImm[15]}}, aImm};
		b = {{16{bImm[15]}}, bImm};
		bz = {16'd0, bImm};
		case (op)
			T_ADD_ANDI: r = (a + b) & bz;
			T_SUB_ORI: r = (a - b) | bz;
			T_AND_XORI: r = (a & b) ^ bz;
			T_OR_ADDI: r = (a | b) + b;
			T_XOR_SLTI: r = ($signed(a ^ b) < $signed(b)) ? 32'd1 : 32'd0;
			T_SLT_XORI: r = (($signed(a) < $signed(b)) ? 32'd1 : 32'd0) ^ bz;
			default: r = 32'd0;
		endcase
		return r;
	endfunction

	// Immediate forced negative so the extension matters
	function automatic caseRow_t randomAluRow(input testOp_t op);
		caseRow_t row;
		logic [31:0] rnd;
		rnd = $random(seed);
		row.opA = rnd[15:0];
		// Negative opA for ANDI, positive for ORI and signed SLT
		if (op == T_ADD_ANDI) begin
			row.opA[15] = 1'b1;
		end else if (op == T_SUB_ORI || op == T_SLT_XORI) begin
			row.opA[15] = 1'b0;
		end
		rnd = $random(seed);
		row.opB = rnd[15:0] | 16'h8000;
		row.op = op;
		row.expAddr = STORE_ADDR;
		row.expData = expectedAlu(op, row.opA, row.opB);
		return row;
	endfunction

	task automatic setupTable();
		seed = 43;
		caseTable[0] = randomAluRow(T_ADD_ANDI);
		caseTable[1] = randomAluRow(T_SUB_ORI);
		caseTable[2] = randomAluRow(T_AND_XORI);
		caseTable[3] = randomAluRow(T_OR_ADDI);
		caseTable[4] = randomAluRow(T_XOR_SLTI);
		caseTable[5] = randomAluRow(T_SLT_XORI);
		// Loaded word is opA:opB
		caseTable[6] = '{T_LW, 16'ha5c3, 16'h7e19, STORE_ADDR, 32'ha5c3_7e19};
		caseTable[7] = '{T_BEQ, 16'h0456, 16'h0456, STORE_ADDR, 32'h0000_2222};
		caseTable[8] = '{T_BEQ, 16'h0456, 16'hfba9, STORE_ADDR, 32'h0000_1111};
		caseTable[9] = '{T_BNE, 16'h8001, 16'h8001, STORE_ADDR, 32'h0000_1111};
		caseTable[10] = '{T_BNE, 16'h0010, 16'h0011, STORE_ADDR, 32'h0000_2222};
		// Jump skips the wrong marker, target stores r0
		caseTable[11] = '{T_JUMP, 16'h7777, 16'h0bad, STORE_ADDR, 32'h0000_0000};
	endtask

	task automatic fillMemory();
		logic [8:0] i;
		// Undefined opcode pattern, unique per word
		for (i = 9'd0; i < 9'd256; i = i + 9'd1) begin
			mem[i[7:0]] = 32'hbad0_0000 ^ {22'd0, i[7:0], 2'b00};
		end
	endtask

	task automatic emit(input logic [31:0] word);
		mem[progPtr] = word;
		progPtr = progPtr + 8'd1;
	endtask

	task automatic buildProgram(input caseRow_t row);
		logic [5:0] funct;
		logic [5:0] iop;
		progPtr = 8'd0;
		funct = FN_ADD;
		iop = OP_ADDI;
		case (row.op)
			T_ADD_ANDI: {funct, iop} = {FN_ADD, OP_ANDI};
			T_SUB_ORI: {funct, iop} = {FN_SUB, OP_ORI};
			T_AND_XORI: {funct, iop} = {FN_AND, OP_XORI};
			T_OR_ADDI: {funct, iop} = {FN_OR, OP_ADDI};
			T_XOR_SLTI: {funct, iop} = {FN_XOR, OP_SLTI};
			T_SLT_XORI: {funct, iop} = {FN_SLT, OP_XORI};
			default: ;
		endcase
		case (row.op)
			T_LW: begin
				mem[LOAD_OFS[9:2]] = {row.opA, row.opB};
				emit(iTypeWord(OP_LW, 5'd0, 5'd5, LOAD_OFS));
				emit(iTypeWord(OP_SW, 5'd0, 5'd5, STORE_OFS));
			end
			T_BEQ, T_BNE: begin
				emit(iTypeWord(OP_ADDI, 5'd0, 5'd1, row.opA));
				emit(iTypeWord(OP_ADDI, 5'd0, 5'd2, row.opB));
				emit(iTypeWord(OP_ORI, 5'd0, 5'd6, FALL_MARK));
				emit(iTypeWord(OP_ORI, 5'd0, 5'd7, TAKEN_MARK));
				// Taken path lands two words past the slot after the branch
				emit(iTypeWord((row.op == T_BEQ) ? OP_BEQ : OP_BNE, 5'd1, 5'd2, 16'd2));
				emit(iTypeWord(OP_SW, 5'd0, 5'd6, STORE_OFS));
				emit(jumpWord(progPtr));
				emit(iTypeWord(OP_SW, 5'd0, 5'd7, STORE_OFS));
			end
			T_JUMP: begin
				emit(iTypeWord(OP_ADDI, 5'd0, 5'd0, row.opA));
				emit(iTypeWord(OP_ORI, 5'd0, 5'd1, row.opB));
				emit(jumpWord(8'd4));
				emit(iTypeWord(OP_SW, 5'd0, 5'd1, STORE_OFS));
				emit(iTypeWord(OP_SW, 5'd0, 5'd0, STORE_OFS));
			end
			default: begin
				emit(iTypeWord(OP_ADDI, 5'd0, 5'd1, row.opA));
				emit(iTypeWord(OP_ADDI, 5'd0, 5'd2, row.opB));
				emit(rTypeWord(funct, 5'd1, 5'd2, 5'd3));
				emit(iTypeWord(iop, 5'd3, 5'd4, row.opB));
				emit(iTypeWord(OP_SW, 5'd0, 5'd4, STORE_OFS));
			end
		endcase
		// Park the core after the store
		emit(jumpWord(progPtr));
	endtask

	task automatic runCase(input int idx);
		caseRow_t row;
		testOp_t op;
		int waitCycles;
		int errorsBefore;
		logic seen;
		logic [31:0] storeAddr;
		logic [31:0] storeData;
		row = caseTable[idx];
		op = row.op;
		errorsBefore = errorCount;
		@(posedge cclk);
		#1;
		rstb = 1'b0;
		fillMemory();
		buildProgram(row);
		repeat (RESET_CYCLES) @(posedge cclk);
		#1;
		rstb = 1'b1;
		waitCycles = 0;
		seen = 1'b0;
		// Sample mid-cycle until the first store strobe
		while (!seen && waitCycles < STORE_LIMIT) begin
			@(negedge cclk);
			waitCycles++;
			seen = memWrite;
		end
		storeAddr = memAddr;
		storeData = writeData;
		assert (seen) else begin
			$display("Case %0d: no store appeared within %0d cycles", idx, STORE_LIMIT);
			errorCount++;
		end
		if (seen) begin
			assert (storeAddr == row.expAddr) else begin
				$display("[ERROR] case %0d memAddr: got %h, expected %h",
					idx, storeAddr, row.expAddr);
				errorCount++;
			end
			assert (storeData == row.expData) else begin
				$display("[ERROR] case %0d writeData: got %h, expected %h",
					idx, storeData, row.expData);
				errorCount++;
			end
			// Store lands at the edge that ends the write cycle
			@(posedge cclk);
			#1;
			mem[storeAddr[9:2]] = storeData;
		end
		if (errorCount == errorsBefore) begin
			passCount++;
			$display("case %0d %s: ok", idx, op.name());
		end else begin
			failCount++;
			$display("case %0d %s: failed", idx, op.name());
		end
	endtask

	initial begin
		rstb = 1'b0;
		errorCount = 0;
		passCount = 0;
		failCount = 0;
		progPtr = 8'd0;
		fillMemory();
		setupTable();
		for (int idx = 0; idx < NUM_ROWS; idx++) begin
			runCase(idx);
		end
		$display("Summary: %0d cases, %0d passed, %0d failed, %0d errors",
			NUM_ROWS, passCount, failCount, errorCount);
		if (failCount == 0 && errorCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Budget covers every case running to its store limit
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before all cases finished", WATCHDOG_NS);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
rtl/mipsPkg.sv
rtl/alu.sv
rtl/regFile.sv
rtl/programCounter.sv
rtl/cpuDatapath.sv
rtl/aluDecoder.sv
rtl/controlUnit.sv
rtl/mipsMulticycle.sv
bench/cpuTb.sv

// File: rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import mipsPkg::*; (
	input wire [31:0] a,
	input wire [31:0] b,
	input aluCtrl_t aluControl,
	output logic [31:0] result,
	output logic zero
);

	logic [31:0] sum;
	logic [31:0] diff;
	logic lessThan;

	assign sum = a + b;
	assign diff = a - b;

	// Signed compare for SLT and SLTI
	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (aluControl)
			ADD: result = sum;
			SUB: result = diff;
			AND: result = a & b;
			OR: result = a | b;
			XOR: result = a ^ b;
			SLT: result = {31'b0, lessThan};
			// Reserved codes
			default: result = 32'b0;
		endcase
	end

	// Branch compare uses this after SUB
	assign zero = (result == 32'b0);

endmodule

`default_nettype wire

// File: rtl/aluDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module aluDecoder import mipsPkg::*; (
	input aluOp_t aluOp,
	input instr_t instr,
	output aluCtrl_t aluControl
);

	always_comb begin
		case (aluOp)
			ALU_ADD: aluControl = ADD;
			ALU_SUB: aluControl = SUB;
			ALU_FUNCT: begin
				// R-format, use funct field
				case (instr.r.funct)
					FN_ADD: aluControl = ADD;
					FN_SUB: aluControl = SUB;
					FN_AND: aluControl = AND;
					FN_OR: aluControl = OR;
					FN_XOR: aluControl = XOR;
					FN_SLT: aluControl = SLT;
					default: aluControl = ADD;
				endcase
			end
			ALU_IMM: begin
				// I-format, operation implied by opcode
				case (instr.i.opcode)
					OP_ADDI: aluControl = ADD;
					OP_SLTI: aluControl = SLT;
					OP_ANDI: aluControl = AND;
					OP_ORI: aluControl = OR;
					OP_XORI: aluControl = XOR;
					default: aluControl = ADD;
				endcase
			end
			default: aluControl = ADD;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit import mipsPkg::*; (
	input wire cclk,
	input wire rstb,
	input instr_t instr,
	output ctrl_t ctrl
);

	cpuState_t state;
	cpuState_t nextState;
	logic [5:0] opcode;
	logic zeroExtImm;

	assign opcode = instr.i.opcode;

	// Logical immediates take zero extension
	assign zeroExtImm = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);

	// State register
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			state <= FETCH;
		end else begin
			state <= nextState;
		end
	end

	// Sequencing
	always_comb begin
		nextState = FETCH;
		case (state)
			FETCH: nextState = DECODE;
			DECODE: begin
				case (opcode)
					OP_RTYPE: nextState = EXECUTE;
					OP_LW, OP_SW: nextState = MEM_ADR;
					OP_BEQ, OP_BNE: nextState = BRANCH;
					OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI: nextState = ITYPE_EXECUTE;
					OP_J: nextState = JUMP;
					// Unknown opcode drops back to fetch
					default: nextState = FETCH;
				endcase
			end
			MEM_ADR: nextState = (opcode == OP_LW) ? MEM_READ : MEM_WRITE;
			MEM_READ: nextState = MEM_WRITEBACK;
			EXECUTE: nextState = ALU_WRITEBACK;
			ITYPE_EXECUTE: nextState = ITYPE_WRITEBACK;
			// Writebacks, store, branch and jump all end here
			default: nextState = FETCH;
		endcase
	end

	// Per-state control decode
	always_comb begin
		ctrl = '0;
		case (state)
			FETCH: begin
				// PC + 4 into PC, word into IR
				ctrl.aluSrcB = SRCB_FOUR;
				ctrl.pcSrc = PC_ALU;
				ctrl.irWrite = 1'b1;
				ctrl.pcWrite = 1'b1;
			end
			DECODE: begin
				// Branch target ready in ALUOut
				ctrl.aluSrcB = SRCB_IMMSHIFT;
				ctrl.extOp = 1'b1;
			end
			MEM_ADR: begin
				ctrl.aluSrcA = 2'd1;
				ctrl.aluSrcB = SRCB_IMM;
				ctrl.extOp = 1'b1;
			end
			MEM_READ: begin
				ctrl.iOrD = 1'b1;
			end
			MEM_WRITEBACK: begin
				// Load result into rt
				ctrl.regDst = 2'd0;
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			MEM_WRITE: begin
				ctrl.iOrD = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			EXECUTE: begin
				ctrl.aluSrcA = 2'd1;
				ctrl.aluSrcB = SRCB_REG;
				ctrl.aluOp = ALU_FUNCT;
			end
			ALU_WRITEBACK: begin
				// R-type result into rd
				ctrl.regDst = 2'd1;
				ctrl.regWrite = 1'b1;
			end
			BRANCH: begin
				// Compare A and B, target from ALUOut
				ctrl.aluSrcA = 2'd1;
				ctrl.aluSrcB = SRCB_REG;
				ctrl.aluOp = ALU_SUB;
				ctrl.pcSrc = PC_ALUOUT;
				ctrl.branch = (opcode == OP_BNE) ? 2'b10 : 2'b01;
			end
			ITYPE_EXECUTE: begin
				ctrl.aluSrcA = 2'd1;
				ctrl.aluSrcB = SRCB_IMM;
				ctrl.aluOp = ALU_IMM;
				ctrl.extOp = !zeroExtImm;
			end
			ITYPE_WRITEBACK: begin
				// Immediate result goes to rt
				ctrl.regDst = 2'd0;
				ctrl.regWrite = 1'b1;
			end
			JUMP: begin
				ctrl.pcSrc = PC_JUMP;
				ctrl.pcWrite = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/cpuDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module cpuDatapath import mipsPkg::*; (
	input wire cclk,
	input wire rstb,
	input ctrl_t ctrl,
	input aluCtrl_t aluControl,
	input wire [31:0] readData,
	output instr_t instr,
	output logic [31:0] memAddr,
	output logic [31:0] writeData
);

	logic [31:0] pc;
	logic [31:0] dataReg;
	logic [31:0] aReg;
	logic [31:0] bReg;
	logic [31:0] aluOut;
	logic [31:0] rd1;
	logic [31:0] rd2;
	logic [31:0] immExt;
	logic [31:0] srcA;
	logic [31:0] srcB;
	logic [31:0] aluResult;
	logic [31:0] writeBack;
	logic [4:0] writeReg;
	logic zero;

	// Instruction register, loaded only in fetch
	always_ff @(posedge cclk) begin
		if (ctrl.irWrite) begin
			instr <= readData;
		end
	end

	// Staging registers, captured every cycle
	always_ff @(posedge cclk) begin
		dataReg <= readData;
		aReg <= rd1;
		bReg <= rd2;
		aluOut <= aluResult;
	end

	// PC for fetch, ALUOut for data access
	assign memAddr = ctrl.iOrD ? aluOut : pc;
	assign writeData = bReg;

	// rt for loads and immediates, rd for R-type
	assign writeReg = (ctrl.regDst == 2'd1) ? instr.r.rd : instr.r.rt;
	assign writeBack = ctrl.memToReg ? dataReg : aluOut;

	regFile i_regFile (
		.cclk(cclk),
		.readAddr1(instr.r.rs),
		.readAddr2(instr.r.rt),
		.writeAddr(writeReg),
		.writeData(writeBack),
		.writeEnable(ctrl.regWrite),
		.readData1(rd1),
		.readData2(rd2)
	);

	// Sign or zero extension
	assign immExt = ctrl.extOp ? {{16{instr.i.imm16[15]}}, instr.i.imm16}
		: {16'b0, instr.i.imm16};

	assign srcA = (ctrl.aluSrcA == 2'd1) ? aReg : pc;

	always_comb begin
		case (ctrl.aluSrcB)
			SRCB_REG: srcB = bReg;
			SRCB_FOUR: srcB = 32'd4;
			SRCB_IMM: srcB = immExt;
			// Word offset for branch target
			SRCB_IMMSHIFT: srcB = {immExt[29:0], 2'b00};
			default: srcB = bReg;
		endcase
	end

	alu i_alu (
		.a(srcA),
		.b(srcB),
		.aluControl(aluControl),
		.result(aluResult),
		.zero(zero)
	);

	programCounter i_programCounter (
		.cclk(cclk),
		.rstb(rstb),
		.ctrl(ctrl),
		.zero(zero),
		.aluResult(aluResult),
		.aluOut(aluOut),
		.jumpTarget(instr.j.target26),
		.pc(pc)
	);

endmodule

`default_nettype wire

// File: rtl/mipsMulticycle.sv
`timescale 1ns/1ps
`default_nettype none

module mipsMulticycle import mipsPkg::*; (
	input wire cclk,
	input wire rstb,
	input wire [31:0] readData,
	output logic [31:0] memAddr,
	output logic [31:0] writeData,
	output logic memWrite
);

	ctrl_t ctrl;
	instr_t instr;
	aluCtrl_t aluControl;

	// Sequencer, driven by the IR contents
	controlUnit i_controlUnit (
		.cclk(cclk),
		.rstb(rstb),
		.instr(instr),
		.ctrl(ctrl)
	);

	aluDecoder i_aluDecoder (
		.aluOp(ctrl.aluOp),
		.instr(instr),
		.aluControl(aluControl)
	);

	cpuDatapath i_cpuDatapath (
		.cclk(cclk),
		.rstb(rstb),
		.ctrl(ctrl),
		.aluControl(aluControl),
		.readData(readData),
		.instr(instr),
		.memAddr(memAddr),
		.writeData(writeData)
	);

	// Store strobe straight from decode
	assign memWrite = ctrl.memWrite;

endmodule

`default_nettype wire

// File: rtl/mipsPkg.sv
`default_nettype none

package mipsPkg;

	// Primary opcodes, standard MIPS encoding
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_J     = 6'h02;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_BNE   = 6'h05;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_SLTI  = 6'h0a;
	localparam logic [5:0] OP_ANDI  = 6'h0c;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_XORI  = 6'h0e;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;

	// R-type funct codes
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_XOR = 6'h26;
	localparam logic [5:0] FN_SLT = 6'h2a;

	// Next-PC select
	localparam logic [1:0] PC_ALU    = 2'd0;
	localparam logic [1:0] PC_ALUOUT = 2'd1;
	localparam logic [1:0] PC_JUMP   = 2'd2;

	// ALU B operand select
	localparam logic [1:0] SRCB_REG      = 2'd0;
	localparam logic [1:0] SRCB_FOUR     = 2'd1;
	localparam logic [1:0] SRCB_IMM      = 2'd2;
	localparam logic [1:0] SRCB_IMMSHIFT = 2'd3;

	typedef enum logic [3:0] {
		FETCH, DECODE, MEM_ADR, MEM_READ, MEM_WRITEBACK, MEM_WRITE,
		EXECUTE, ALU_WRITEBACK, BRANCH, ITYPE_EXECUTE, ITYPE_WRITEBACK, JUMP
	} cpuState_t;

	// ALU_IMM means the operation comes from the opcode
	typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_FUNCT, ALU_IMM} aluOp_t;

	// Codes 6 to 15 reserved
	typedef enum logic [3:0] {ADD, SUB, AND, OR, XOR, SLT} aluCtrl_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFormat_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} iFormat_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target26;
	} jFormat_t;

	// One instruction word, three views
	typedef union packed {
		rFormat_t r;
		iFormat_t i;
		jFormat_t j;
	} instr_t;

	typedef struct packed {
		logic       memToReg;
		logic       iOrD;
		logic [1:0] regDst;
		logic [1:0] pcSrc;
		logic [1:0] aluSrcA;
		logic [1:0] aluSrcB;
		// Upper bit BNE, lower bit BEQ
		logic [1:0] branch;
		logic       irWrite;
		logic       memWrite;
		logic       pcWrite;
		logic       regWrite;
		logic       extOp;
		aluOp_t     aluOp;
	} ctrl_t;

endpackage

`default_nettype wire

// File: rtl/programCounter.sv
`timescale 1ns/1ps
`default_nettype none

module programCounter import mipsPkg::*; (
	input wire cclk,
	input wire rstb,
	input ctrl_t ctrl,
	input wire zero,
	input wire [31:0] aluResult,
	input wire [31:0] aluOut,
	input wire [25:0] jumpTarget,
	output logic [31:0] pc
);

	logic pcEnable;
	logic [31:0] nextPc;

	// Unconditional write, BEQ on zero, BNE on nonzero
	assign pcEnable = ctrl.pcWrite
		| (ctrl.branch[0] & zero)
		| (ctrl.branch[1] & ~zero);

	always_comb begin
		case (ctrl.pcSrc)
			PC_ALU: nextPc = aluResult;
			PC_ALUOUT: nextPc = aluOut;
			// Region bits kept from current PC
			PC_JUMP: nextPc = {pc[31:28], jumpTarget, 2'b00};
			default: nextPc = aluResult;
		endcase
	end

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			pc <= 32'b0;
		end else if (pcEnable) begin
			pc <= nextPc;
		end
	end

endmodule

`default_nettype wire

// File: rtl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input wire cclk,
	input wire [4:0] readAddr1,
	input wire [4:0] readAddr2,
	input wire [4:0] writeAddr,
	input wire [31:0] writeData,
	input wire writeEnable,
	output logic [31:0] readData1,
	output logic [31:0] readData2
);

	logic [31:0] regs [32];

	// Writes to r0 are dropped
	always_ff @(posedge cclk) begin
		if (writeEnable && (writeAddr != 5'd0)) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Async reads, r0 forced to zero
	assign readData1 = (readAddr1 == 5'd0) ? 32'b0 : regs[readAddr1];
	assign readData2 = (readAddr2 == 5'd0) ? 32'b0 : regs[readAddr2];

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f filelist.f --top-module cpuTb -o cpuSim

output="$(./obj_dir/cpuSim)"
echo "$output"

if grep -q "ALL CHECKS PASSED" <<< "$output"; then
	exit 0
else
	exit 1
fi
